//--- files.f
+incdir+.
sram_pkg.sv
latency_lfsr.sv
latency_timer.sv
sram_array.sv
sram_ctrl_fsm.sv
axi_sram_top.sv
tb_axi_sram.sv

//--- Bender.yml
package:
  name: axi_sram

export_include_dirs:
  - .

sources:
  - sram_pkg.sv
  - latency_lfsr.sv
  - latency_timer.sv
  - sram_array.sv
  - sram_ctrl_fsm.sv
  - axi_sram_top.sv
  - target: simulation
    files:
      - tb_axi_sram.sv

//--- tb_axi_sram.sv
`include "sram_settings.svh"

module tb_axi_sram import sram_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS    = 300;
    localparam int MAX_STALL  = 6;
    localparam int MIN_LAT    = 2;
    localparam int MAX_LAT    = (1 << `SRAM_DELAY_W) + 1;
    localparam int MEM_BYTES  = `SRAM_DEPTH_WORDS * 4;
    // an op is at most two transactions, each with two stalls and a few idle cycles
    localparam int TIMEOUT = 2 * NUM_OPS * (MAX_LAT + 2 * MAX_STALL + 8) * CLK_PERIOD
                           + 64 * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    ar_req_t ar_req;
    logic    ar_valid;
    logic    ar_ready;
    aw_req_t aw_req;
    logic    aw_valid;
    logic    aw_ready;
    w_req_t  w_req;
    logic    w_valid;
    logic    w_ready;
    r_rsp_t  r_rsp;
    logic    r_valid;
    logic    r_ready;
    b_rsp_t  b_rsp;
    logic    b_valid;
    logic    b_ready;

    logic [31:0] rng;
    data_t       model_mem [`SRAM_DEPTH_WORDS];
    strb_t       written   [`SRAM_DEPTH_WORDS];
    int          mismatch_count;
    int          other_count;

    axi_sram_top i_axi_sram_top (
        .clk, .rst_n,
        .ar_req, .ar_valid, .ar_ready,
        .aw_req, .aw_valid, .aw_ready,
        .w_req, .w_valid, .w_ready,
        .r_rsp, .r_valid, .r_ready,
        .b_rsp, .b_valid, .b_ready
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic data_t strb_mask(input strb_t s);
        data_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    // mostly a small window so reads hit written words, sometimes past the end
    function automatic addr_t pick_addr(input bit allow_oor);
        logic [31:0] r;
        r = next_rand();
        if (allow_oor && r[2:0] == 3'd0) begin
            return MEM_BYTES + (next_rand() & 32'h000f_fffc);
        end else if (r[3]) begin
            return (next_rand() % `SRAM_DEPTH_WORDS) << 2;
        end
        return (next_rand() % 32) << 2;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_latency(input string kind, input int lat);
        if (lat < MIN_LAT || lat > MAX_LAT) begin
            $display("%0t %s response came after %0d cycles, outside %0d to %0d",
                     $time, kind, lat, MIN_LAT, MAX_LAT);
            other_count++;
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data, input strb_t strb,
                            input bit early_w, input bit with_read);
        int        stall;
        int        lat;
        b_rsp_t    held;
        resp_t     exp_resp;
        word_idx_t idx;

        exp_resp = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
        idx      = addr[$bits(word_idx_t)+1:2];
        @(negedge clk);
        aw_req.addr = addr;
        aw_valid    = 1'b1;
        if (with_read) begin
            ar_req.addr = addr;
            ar_valid    = 1'b1;
        end
        if (early_w) begin
            w_req.data = data;
            w_req.strb = strb;
            w_valid    = 1'b1;
        end
        #1;
        // w beat before aw is held off, a read arriving together loses
        check("w_ready", 0, w_ready);
        check("ar_ready", 0, ar_ready);
        while (!aw_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        aw_valid = 1'b0;
        if (!early_w) begin
            stall = next_rand() % (MAX_STALL + 1);
            repeat (stall) begin
                #1;
                check("w_ready", 1, w_ready);
                @(negedge clk);
            end
            w_req.data = data;
            w_req.strb = strb;
            w_valid    = 1'b1;
        end
        #1;
        check("w_ready", 1, w_ready);
        @(posedge clk);
        @(negedge clk);
        w_valid = 1'b0;
        lat     = 1;
        while (!b_valid) begin
            @(negedge clk);
            lat++;
        end
        check_latency("write", lat);
        held  = b_rsp;
        stall = next_rand() % (MAX_STALL + 1);
        repeat (stall) begin
            @(negedge clk);
            check("b_valid", 1, b_valid);
            check("b_rsp", held, b_rsp);
        end
        check("b_rsp.resp", exp_resp, b_rsp.resp);
        b_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        b_ready = 1'b0;
        check("b_valid", 0, b_valid);
        if (exp_resp == RESP_OKAY) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_mem[idx][8*b +: 8] = data[8*b +: 8];
                    written[idx][b]          = 1'b1;
                end
            end
        end
    endtask

    task automatic do_read(input addr_t addr, input bit held_valid);
        int        stall;
        int        lat;
        r_rsp_t    first;
        resp_t     exp_resp;
        word_idx_t idx;
        data_t     mask;

        exp_resp = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
        idx      = addr[$bits(word_idx_t)+1:2];
        mask     = strb_mask(written[idx]);
        if (!held_valid) begin
            @(negedge clk);
            ar_req.addr = addr;
            ar_valid    = 1'b1;
        end
        #1;
        while (!ar_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
        lat      = 1;
        while (!r_valid) begin
            @(negedge clk);
            lat++;
        end
        check_latency("read", lat);
        first = r_rsp;
        stall = next_rand() % (MAX_STALL + 1);
        repeat (stall) begin
            @(negedge clk);
            check("r_valid", 1, r_valid);
            check("r_rsp", first, r_rsp);
        end
        check("r_rsp.resp", exp_resp, r_rsp.resp);
        if (exp_resp == RESP_SLVERR) begin
            check("r_rsp.data", 0, r_rsp.data);
        end else begin
            // bytes never written are unknown in the array
            check("r_rsp.data", model_mem[idx] & mask, r_rsp.data & mask);
        end
        r_ready = 1'b1;
        @(posedge clk);
        @(negedge clk);
        r_ready = 1'b0;
        check("r_valid", 0, r_valid);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout after %0d time units, the DUT stopped responding", TIMEOUT);
        $display("mismatches %0d, other errors %0d", mismatch_count, other_count + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        addr_t       addr;
        data_t       data;
        logic [31:0] rnd;
        int          kind;

        rng            = 32'd66;
        mismatch_count = 0;
        other_count    = 0;
        rst_n          = 1'b0;
        ar_req         = '0;
        ar_valid       = 1'b0;
        aw_req         = '0;
        aw_valid       = 1'b0;
        w_req          = '0;
        w_valid        = 1'b0;
        r_ready        = 1'b0;
        b_ready        = 1'b0;
        for (int i = 0; i < `SRAM_DEPTH_WORDS; i++) begin
            written[i] = '0;
        end
        repeat (16) @(negedge clk);
        check("ar_ready", 0, ar_ready);
        check("aw_ready", 0, aw_ready);
        check("w_ready", 0, w_ready);
        check("r_valid", 0, r_valid);
        check("b_valid", 0, b_valid);
        rst_n = 1'b1;
        // one quiet cycle after reset, then idle with both address readies up
        @(negedge clk);
        #1;
        check("ar_ready", 1, ar_ready);
        check("aw_ready", 1, aw_ready);
        check("w_ready", 0, w_ready);

        for (int n = 0; n < NUM_OPS; n++) begin
            kind = next_rand() % 8;
            data = next_rand();
            rnd  = next_rand();
            if (kind < 4) begin
                addr = pick_addr(1'b1);
                do_write(addr, data, rnd[3:0], rnd[5:4] == 2'b00, 1'b0);
            end else if (kind < 7) begin
                addr = pick_addr(1'b1);
                do_read(addr, 1'b0);
            end else begin
                addr = pick_addr(1'b0);
                do_write(addr, data, rnd[3:0], 1'b0, 1'b1);
                do_read(addr, 1'b1);
            end
        end

        @(negedge clk);
        $display("mismatches %0d, other errors %0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- axi_sram_top.sv
module axi_sram_top import sram_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  ar_req_t ar_req,
    input  logic    ar_valid,
    output logic    ar_ready,

    input  aw_req_t aw_req,
    input  logic    aw_valid,
    output logic    aw_ready,

    input  w_req_t  w_req,
    input  logic    w_valid,
    output logic    w_ready,

    output r_rsp_t  r_rsp,
    output logic    r_valid,
    input  logic    r_ready,

    output b_rsp_t  b_rsp,
    output logic    b_valid,
    input  logic    b_ready
);

    logic      lfsr_step;
    delay_t    delay;
    logic      timer_start;
    logic      timer_done;
    logic      rd_en;
    logic      wr_en;
    word_idx_t idx;
    data_t     wdata;
    strb_t     strb;
    data_t     rd_data;

    sram_ctrl_fsm i_ctrl (
        .clk, .rst_n,
        .ar_req, .ar_valid, .ar_ready,
        .aw_req, .aw_valid, .aw_ready,
        .w_req, .w_valid, .w_ready,
        .r_rsp, .r_valid, .r_ready,
        .b_rsp, .b_valid, .b_ready,
        .lfsr_step, .timer_start, .timer_done,
        .rd_en, .wr_en, .idx, .wdata, .strb, .rd_data
    );

    latency_lfsr i_lfsr (
        .clk, .rst_n,
        .step  (lfsr_step),
        .delay (delay)
    );

    latency_timer i_timer (
        .clk, .rst_n,
        .start (timer_start),
        .load  (delay),
        .done  (timer_done)
    );

    sram_array i_array (
        .clk, .rd_en, .wr_en, .idx, .wdata, .strb,
        .rdata (rd_data)
    );

endmodule

//--- sram_ctrl_fsm.sv
`include "sram_settings.svh"

module sram_ctrl_fsm import sram_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // read address
    input  ar_req_t   ar_req,
    input  logic      ar_valid,
    output logic      ar_ready,

    // write address
    input  aw_req_t   aw_req,
    input  logic      aw_valid,
    output logic      aw_ready,

    // write data
    input  w_req_t    w_req,
    input  logic      w_valid,
    output logic      w_ready,

    // read response
    output r_rsp_t    r_rsp,
    output logic      r_valid,
    input  logic      r_ready,

    // write response
    output b_rsp_t    b_rsp,
    output logic      b_valid,
    input  logic      b_ready,

    // delay source and timer
    output logic      lfsr_step,
    output logic      timer_start,
    input  logic      timer_done,

    // storage array
    output logic      rd_en,
    output logic      wr_en,
    output word_idx_t idx,
    output data_t     wdata,
    output strb_t     strb,
    input  data_t     rd_data
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // low for the first cycle after reset so no handshake happens during it
    logic armed;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;

    addr_t     sel_addr;
    word_idx_t idx_q;
    logic      in_range_q;
    data_t     wdata_q;
    strb_t     strb_q;

    function automatic logic addr_in_range(input addr_t addr);
        return (addr >> 2) < `SRAM_DEPTH_WORDS;
    endfunction

    function automatic word_idx_t addr_to_idx(input addr_t addr);
        return addr[$bits(word_idx_t)+1:2];
    endfunction

    // handshakes
    assign aw_ready = armed && (state == IDLE);
    // write wins a tie with a read
    assign ar_ready = armed && (state == IDLE) && !aw_valid;
    assign w_ready  = (state == WR_DATA);
    assign r_valid  = (state == RD_RESP);
    assign b_valid  = (state == WR_RESP);

    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid  && w_ready;
    assign r_hs  = r_valid  && r_ready;
    assign b_hs  = b_valid  && b_ready;

    // lfsr steps per accepted address, the wait starts once the data is known
    assign lfsr_step   = ar_hs || aw_hs;
    assign timer_start = ar_hs || w_hs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            armed <= 1'b0;
        end else begin
            state <= state_nxt;
            armed <= 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (aw_hs) begin
                    state_nxt = WR_DATA;
                end else if (ar_hs) begin
                    state_nxt = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (timer_done) begin
                    state_nxt = RD_RESP;
                end
            end
            RD_RESP: begin
                if (r_hs) begin
                    state_nxt = IDLE;
                end
            end
            WR_DATA: begin
                if (w_hs) begin
                    state_nxt = WR_WAIT;
                end
            end
            WR_WAIT: begin
                if (timer_done) begin
                    state_nxt = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_hs) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // address of whichever channel is being accepted
    assign sel_addr = aw_valid ? aw_req.addr : ar_req.addr;

    // range decided once here, the array never sees a bad index
    always_ff @(posedge clk) begin
        if (ar_hs || aw_hs) begin
            idx_q      <= addr_to_idx(sel_addr);
            in_range_q <= addr_in_range(sel_addr);
        end
        if (w_hs) begin
            wdata_q <= w_req.data;
            strb_q  <= w_req.strb;
        end
    end

    // array access on the last wait cycle
    assign rd_en = (state == RD_WAIT) && timer_done && in_range_q;
    assign wr_en = (state == WR_WAIT) && timer_done && in_range_q;
    assign idx   = idx_q;
    assign wdata = wdata_q;
    assign strb  = strb_q;

    // responses come from held registers, stable under back-pressure
    always_comb begin
        r_rsp.data = in_range_q ? rd_data : '0;
        r_rsp.resp = in_range_q ? RESP_OKAY : RESP_SLVERR;
        b_rsp.resp = in_range_q ? RESP_OKAY : RESP_SLVERR;
    end

    a_r_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_rsp))
    );

    a_one_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ar_hs && aw_hs)
    );

endmodule

//--- sram_array.sv
`include "sram_settings.svh"

module sram_array import sram_pkg::*; (
    input  logic      clk,
    input  logic      rd_en,
    input  logic      wr_en,
    input  word_idx_t idx,
    input  data_t     wdata,
    input  strb_t     strb,
    output data_t     rdata
);

    localparam int BYTES = `SRAM_DATA_W / 8;

    data_t mem [`SRAM_DEPTH_WORDS];

    // byte lanes with their strobe set are written, the rest keep their value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BYTES; b++) begin
                if (strb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, rdata holds until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[idx];
        end
    end

endmodule

//--- latency_timer.sv
module latency_timer import sram_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  delay_t load,
    output logic   done
);

    delay_t count;
    logic   busy;

    // count down from load, done on the cycle the count sits at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (start) begin
            count <= load;
            busy  <= 1'b1;
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // a zero load still takes one cycle
    assign done = busy && (count == '0);

    // the controller only starts a new wait once the last one expired
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> !busy
    );

endmodule

//--- latency_lfsr.sv
`include "sram_settings.svh"

module latency_lfsr import sram_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   step,
    output delay_t delay
);

    lfsr_t state;
    logic  feedback;

    // taps 0, 2, 3 and 4, shifted in from the top
    assign feedback = ^state[4:2] ^ state[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // nonzero seed, zero would lock the register
            state <= 8'h01;
        end else if (step) begin
            state <= {feedback, state[7:1]};
        end
    end

    // low bits only, keeps the wait short
    assign delay = state[`SRAM_DELAY_W-1:0];

    // the all-zero state must never be reached from the seed
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        state != '0
    );

endmodule

//--- sram_pkg.sv
`include "sram_settings.svh"

package sram_pkg;

    // widths with a meaning of their own
    typedef logic [`SRAM_ADDR_W-1:0]                addr_t;
    typedef logic [`SRAM_DATA_W-1:0]                data_t;
    typedef logic [`SRAM_DATA_W/8-1:0]              strb_t;
    typedef logic [1:0]                             resp_t;
    typedef logic [$clog2(`SRAM_DEPTH_WORDS)-1:0]   word_idx_t;
    typedef logic [`SRAM_DELAY_W-1:0]               delay_t;
    typedef logic [7:0]                             lfsr_t;

    // axi response codes in use
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // read address channel
    typedef struct packed {
        addr_t addr;
    } ar_req_t;

    // write address channel
    typedef struct packed {
        addr_t addr;
    } aw_req_t;

    // write data channel
    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_req_t;

    // read data channel
    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_rsp_t;

    // write response channel
    typedef struct packed {
        resp_t resp;
    } b_rsp_t;

    // controller states
    // one transaction in flight, reads and writes never overlap
    typedef enum logic [2:0] {
        IDLE,
        RD_WAIT,
        RD_RESP,
        WR_DATA,
        WR_WAIT,
        WR_RESP
    } ctrl_state_e;

endpackage

//--- sram_settings.svh
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// AXI address width in bits
`define SRAM_ADDR_W 32

// data bus width, also the storage word width
`define SRAM_DATA_W 32

// storage size in words
`define SRAM_DEPTH_WORDS 1024

// lfsr bits taken as the wait length
// 4 bits gives 0 to 15 extra cycles per response
`define SRAM_DELAY_W 4

`endif
